// File: design/acc_flag_unit.sv
`timescale 1ns/1ps
`include "z80_settings.svh"

module acc_flag_unit (
  input  logic                 clk,
  input  logic                 reset,
  data_bus_if.acc_peer         bus,
  input  logic                 ex_af,
  input  logic                 alu_en,
  input  z80_alu_pkg::alu_op_t alu_op,
  output z80_bus_pkg::byte_t   flags
);

  z80_bus_pkg::byte_t   a_reg;
  z80_bus_pkg::byte_t   a_shadow;
  z80_alu_pkg::flags_t  f_reg;
  z80_alu_pkg::flags_t  f_shadow;

  z80_bus_pkg::byte_t   addend;
  logic                 carry_in;
  logic                 is_sub;
  logic [`Z80_DATA_W:0] sum;
  logic [4:0]           half_sum;
  z80_bus_pkg::byte_t   alu_result;
  z80_bus_pkg::byte_t   alu_flags;

  // --------------------
  // bus drive
  // --------------------
  assign bus.acc_req  = bus.drive_en &&
                        (bus.src_sel == z80_bus_pkg::REG_A || bus.src_sel == z80_bus_pkg::REG_F);
  assign bus.acc_data = (bus.src_sel == z80_bus_pkg::REG_F) ? z80_bus_pkg::byte_t'(f_reg) : a_reg;

  // --------------------
  // byte ALU
  // --------------------

  // every arithmetic op runs through one adder, subtraction adds the
  // inverted operand with a carry in and INC/DEC add +1 or -1
  always_comb begin
    addend   = bus.bus_value;
    carry_in = 1'b0;
    is_sub   = 1'b0;
    case (alu_op)
      z80_alu_pkg::ADC: carry_in = f_reg.c;
      z80_alu_pkg::SUB: begin
        addend   = ~bus.bus_value;
        carry_in = 1'b1;
        is_sub   = 1'b1;
      end
      z80_alu_pkg::INC: begin
        addend   = '0;
        carry_in = 1'b1;
      end
      z80_alu_pkg::DEC: begin
        addend = '1;
        is_sub = 1'b1;
      end
      default: ;
    endcase
    sum      = {1'b0, a_reg} + {1'b0, addend} + carry_in;
    half_sum = {1'b0, a_reg[3:0]} + {1'b0, addend[3:0]} + carry_in;
  end

  // flags start from the old F so that anything an op does not name survives
  always_comb begin
    alu_flags  = f_reg;
    alu_result = sum[`Z80_DATA_W-1:0];
    case (alu_op)
      z80_alu_pkg::ADD, z80_alu_pkg::ADC, z80_alu_pkg::SUB,
      z80_alu_pkg::INC, z80_alu_pkg::DEC: begin
        alu_flags[`Z80_FLAG_S] = sum[7];
        alu_flags[`Z80_FLAG_Z] = (sum[7:0] == '0);
        // a borrow is the missing carry of the inverted add
        alu_flags[`Z80_FLAG_H] = half_sum[4] ^ is_sub;
        // overflow when both inputs agree in sign and the result does not
        alu_flags[`Z80_FLAG_PV] = (a_reg[7] == addend[7]) && (sum[7] != a_reg[7]);
        alu_flags[`Z80_FLAG_N] = is_sub;
        // INC and DEC leave C alone as on the real part
        if (alu_op != z80_alu_pkg::INC && alu_op != z80_alu_pkg::DEC) begin
          alu_flags[`Z80_FLAG_C] = sum[`Z80_DATA_W] ^ is_sub;
        end
      end
      z80_alu_pkg::CPL: begin
        alu_result             = ~a_reg;
        alu_flags[`Z80_FLAG_H] = 1'b1;
        alu_flags[`Z80_FLAG_N] = 1'b1;
      end
      z80_alu_pkg::CCF: begin
        alu_result             = a_reg;
        alu_flags[`Z80_FLAG_H] = f_reg.c;
        alu_flags[`Z80_FLAG_N] = 1'b0;
        alu_flags[`Z80_FLAG_C] = ~f_reg.c;
      end
      default: alu_result = a_reg;
    endcase
  end

  // --------------------
  // A and F update
  // --------------------

  // only one of exchange, ALU write or bus load is active in any cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      a_reg    <= '0;
      a_shadow <= '0;
      f_reg    <= '0;
      f_shadow <= '0;
    end else if (ex_af) begin
      a_reg    <= a_shadow;
      a_shadow <= a_reg;
      f_reg    <= f_shadow;
      f_shadow <= f_reg;
    end else if (alu_en) begin
      a_reg <= alu_result;
      f_reg <= z80_alu_pkg::flags_t'(alu_flags);
    end else if (bus.load_en) begin
      if (bus.dst_sel == z80_bus_pkg::REG_A) begin
        a_reg <= bus.bus_value;
      end else if (bus.dst_sel == z80_bus_pkg::REG_F) begin
        f_reg <= z80_alu_pkg::flags_t'(bus.bus_value);
      end
    end
  end

  assign flags = f_reg;

endmodule

// File: design/data_bus_arbiter.sv
`timescale 1ns/1ps

module data_bus_arbiter (
  data_bus_if.arbiter bus
);

  z80_bus_pkg::byte_t winner_data;

  // --------------------
  // fixed priority
  // --------------------

  // the accumulator unit wins over the register file, and the immediate
  // byte only reaches the bus when neither peer asks for it
  always_comb begin
    if (bus.acc_req) begin
      winner_data = bus.acc_data;
    end else if (bus.reg_req) begin
      winner_data = bus.reg_data;
    end else if (bus.imm_req) begin
      winner_data = bus.imm_data;
    end else begin
      // an idle bus reads as zero
      winner_data = '0;
    end
  end

  assign bus.bus_value = winner_data;

endmodule

// File: design/data_bus_if.sv
`timescale 1ns/1ps

interface data_bus_if;

  // selectors and strobes, all owned by the sequencer
  z80_bus_pkg::reg_sel_t src_sel;
  z80_bus_pkg::reg_sel_t dst_sel;
  logic                  drive_en;
  logic                  load_en;
  logic                  imm_req;
  z80_bus_pkg::byte_t    imm_data;

  // each peer asks for the bus with its own request and data
  logic                  reg_req;
  z80_bus_pkg::byte_t    reg_data;
  logic                  acc_req;
  z80_bus_pkg::byte_t    acc_data;

  // the resolved bus byte that everybody listens to
  z80_bus_pkg::byte_t    bus_value;

  modport sequencer (
    output src_sel, dst_sel, drive_en, load_en, imm_req, imm_data,
    input  bus_value
  );
  modport reg_peer (
    input  src_sel, dst_sel, drive_en, load_en, bus_value,
    output reg_req, reg_data
  );
  modport acc_peer (
    input  src_sel, dst_sel, drive_en, load_en, bus_value,
    output acc_req, acc_data
  );
  modport arbiter (
    input  imm_req, imm_data, reg_req, reg_data, acc_req, acc_data,
    output bus_value
  );

endinterface

// File: design/micro_op_sequencer.sv
`timescale 1ns/1ps

module micro_op_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  z80_bus_pkg::cmd_kind_t cmd_kind,
  input  z80_bus_pkg::reg_sel_t  cmd_dst,
  input  z80_bus_pkg::reg_sel_t  cmd_src,
  input  z80_alu_pkg::alu_op_t   cmd_alu_op,
  input  z80_bus_pkg::byte_t     data_in,
  output logic                   ack,
  output z80_bus_pkg::byte_t     result_data,
  data_bus_if.sequencer          bus,
  output logic                   exx,
  output logic                   ex_af,
  output logic                   alu_en,
  output z80_alu_pkg::alu_op_t   alu_op
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK
  } state_t;

  state_t                 state;
  logic                   in_exec;
  z80_bus_pkg::cmd_kind_t kind_q;
  z80_bus_pkg::reg_sel_t  dst_q;
  z80_bus_pkg::reg_sel_t  src_q;
  z80_bus_pkg::byte_t     data_q;
  z80_alu_pkg::alu_op_t   op_q;

  // --------------------
  // handshake FSM
  // --------------------

  // IDLE waits for req, EXEC is the single bus cycle, ACK waits for req to drop
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      ack         <= 1'b0;
      kind_q      <= z80_bus_pkg::READ;
      result_data <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state  <= EXEC;
            kind_q <= cmd_kind;
          end
        end
        EXEC: begin
          state <= ACK;
          ack   <= 1'b1;
          // exchanges put nothing on the bus, so the last byte stays visible
          if (kind_q != z80_bus_pkg::EXX && kind_q != z80_bus_pkg::EX_AF) begin
            result_data <= bus.bus_value;
          end
        end
        ACK: begin
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // the command fields are captured at acceptance and held until the next one
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      dst_q  <= cmd_dst;
      src_q  <= cmd_src;
      data_q <= data_in;
      op_q   <= cmd_alu_op;
    end
  end

  // --------------------
  // EXEC cycle controls
  // --------------------
  assign in_exec = (state == EXEC);

  // a register is sourced onto the bus for every command that reads one
  assign bus.drive_en = in_exec && (kind_q == z80_bus_pkg::MOVE ||
                                    kind_q == z80_bus_pkg::READ ||
                                    kind_q == z80_bus_pkg::ALU);
  assign bus.imm_req  = in_exec && (kind_q == z80_bus_pkg::LOAD_IMM);
  assign bus.imm_data = data_q;
  assign bus.load_en  = in_exec && (kind_q == z80_bus_pkg::MOVE ||
                                    kind_q == z80_bus_pkg::LOAD_IMM);
  assign bus.src_sel  = src_q;
  assign bus.dst_sel  = dst_q;

  assign alu_en = in_exec && (kind_q == z80_bus_pkg::ALU);
  assign exx    = in_exec && (kind_q == z80_bus_pkg::EXX);
  assign ex_af  = in_exec && (kind_q == z80_bus_pkg::EX_AF);
  assign alu_op = op_q;

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic         clk,
  input  logic         reset,
  data_bus_if.reg_peer bus,
  input  logic         exx
);

  // B, C, D, E, H and L, indexed by their selector code
  localparam int unsigned NUM_REGS = 6;

  z80_bus_pkg::byte_t main_regs   [NUM_REGS];
  z80_bus_pkg::byte_t shadow_regs [NUM_REGS];
  logic               src_own;
  logic               dst_own;

  // codes above L belong to the accumulator unit
  assign src_own = (bus.src_sel <= z80_bus_pkg::REG_L);
  assign dst_own = (bus.dst_sel <= z80_bus_pkg::REG_L);

  // --------------------
  // bus drive
  // --------------------
  assign bus.reg_req  = bus.drive_en && src_own;
  assign bus.reg_data = src_own ? main_regs[bus.src_sel] : '0;

  // --------------------
  // load and exchange
  // --------------------

  // EXX swaps all six pairs in one edge through direct paths, the bus is
  // not involved, and the sequencer never asks for a load in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        main_regs[i]   <= '0;
        shadow_regs[i] <= '0;
      end
    end else if (exx) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        main_regs[i]   <= shadow_regs[i];
        shadow_regs[i] <= main_regs[i];
      end
    end else if (bus.load_en && dst_own) begin
      // a load only ever touches the visible bank
      main_regs[bus.dst_sel] <= bus.bus_value;
    end
  end

endmodule

// File: design/z80_alu_pkg.sv
`include "z80_settings.svh"

package z80_alu_pkg;

  // the seven byte operations, all take A and the bus byte
  typedef enum logic [`Z80_ALU_OP_W-1:0] {
    ADD,
    ADC,
    SUB,
    INC,
    DEC,
    CPL,
    CCF
  } alu_op_t;

  // the F register, f5 and f3 are the undocumented bits that never change here
  typedef struct packed {
    logic s;
    logic z;
    logic f5;
    logic h;
    logic f3;
    logic pv;
    logic n;
    logic c;
  } flags_t;

endpackage

// File: design/z80_bus_pkg.sv
`include "z80_settings.svh"

package z80_bus_pkg;

  // one byte on the internal data bus
  typedef logic [`Z80_DATA_W-1:0] byte_t;

  // register selector, B to L keep the usual Z80 field codes 0 to 5
  // code 6 names F here and code 7 names A
  typedef enum logic [`Z80_SEL_W-1:0] {
    REG_B,
    REG_C,
    REG_D,
    REG_E,
    REG_H,
    REG_L,
    REG_F,
    REG_A
  } reg_sel_t;

  // commands accepted over the req/ack handshake
  typedef enum logic [2:0] {
    LOAD_IMM,
    MOVE,
    READ,
    ALU,
    EXX,
    EX_AF
  } cmd_kind_t;

endpackage

// File: design/z80_datapath.sv
`timescale 1ns/1ps

module z80_datapath (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  z80_bus_pkg::cmd_kind_t cmd_kind,
  input  z80_bus_pkg::reg_sel_t  cmd_dst,
  input  z80_bus_pkg::reg_sel_t  cmd_src,
  input  z80_alu_pkg::alu_op_t   cmd_alu_op,
  input  z80_bus_pkg::byte_t     data_in,
  output logic                   ack,
  output z80_bus_pkg::byte_t     result_data,
  output z80_bus_pkg::byte_t     flags
);

  // strobes from the sequencer that bypass the shared bus
  logic                 exx;
  logic                 ex_af;
  logic                 alu_en;
  z80_alu_pkg::alu_op_t alu_op;

  // the one internal data bus
  data_bus_if bus_i ();

  micro_op_sequencer micro_op_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .cmd_kind    (cmd_kind),
    .cmd_dst     (cmd_dst),
    .cmd_src     (cmd_src),
    .cmd_alu_op  (cmd_alu_op),
    .data_in     (data_in),
    .ack         (ack),
    .result_data (result_data),
    .bus         (bus_i),
    .exx         (exx),
    .ex_af       (ex_af),
    .alu_en      (alu_en),
    .alu_op      (alu_op)
  );

  data_bus_arbiter data_bus_arbiter_i (
    .bus (bus_i)
  );

  reg_file reg_file_i (
    .clk   (clk),
    .reset (reset),
    .bus   (bus_i),
    .exx   (exx)
  );

  acc_flag_unit acc_flag_unit_i (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus_i),
    .ex_af  (ex_af),
    .alu_en (alu_en),
    .alu_op (alu_op),
    .flags  (flags)
  );

endmodule

// File: design/z80_settings.svh
`ifndef Z80_SETTINGS_SVH
`define Z80_SETTINGS_SVH

// --------------------
// datapath widths
// --------------------

// one byte travels on the internal bus
`define Z80_DATA_W 8

// a selector names one of B, C, D, E, H, L, F or A
`define Z80_SEL_W 3

// opcode width of the byte ALU
`define Z80_ALU_OP_W 4

// --------------------
// bit positions inside F
// --------------------
`define Z80_FLAG_S  7
`define Z80_FLAG_Z  6
`define Z80_FLAG_H  4
`define Z80_FLAG_PV 2
`define Z80_FLAG_N  1
`define Z80_FLAG_C  0

`endif

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sources.f --top-module tb_z80_datapath \
    -o tb_z80_datapath &&
  ./obj_dir/tb_z80_datapath | tee /dev/stderr | grep -qx "Testbench passed" ||
  { echo "simulation did not pass"; exit 1; }

// File: sources.f
+incdir+design
design/z80_bus_pkg.sv
design/z80_alu_pkg.sv
design/data_bus_if.sv
design/micro_op_sequencer.sv
design/data_bus_arbiter.sv
design/reg_file.sv
design/acc_flag_unit.sv
design/z80_datapath.sv
tests/z80_datapath_assertions.sv
tests/datapath_checker.sv
tests/tb_z80_datapath.sv

// File: tests/datapath_checker.sv
`timescale 1ns/1ps
`include "z80_settings.svh"

module datapath_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ack,
  input  z80_bus_pkg::cmd_kind_t cmd_kind,
  input  z80_bus_pkg::reg_sel_t  cmd_dst,
  input  z80_bus_pkg::reg_sel_t  cmd_src,
  input  z80_alu_pkg::alu_op_t   cmd_alu_op,
  input  z80_bus_pkg::byte_t     data_in,
  input  z80_bus_pkg::byte_t     result_data,
  input  z80_bus_pkg::byte_t     flags,
  input  string                  test_name,
  input  logic                   test_done,
  input  logic                   run_done,
  output int                     error_count
);

  // model registers indexed by selector code, so F sits at 6 and A at 7
  z80_bus_pkg::byte_t model_regs   [8];
  z80_bus_pkg::byte_t model_shadow [8];
  z80_bus_pkg::byte_t last_result;
  logic               ack_q;
  int                 test_checks;
  int                 test_errors;
  int                 total_checks;
  int                 tests_run;

  // --------------------
  // helpers
  // --------------------

  // two's complement reading of a byte held in an int
  function automatic int as_signed(input int value);
    return (value > 127) ? value - 256 : value;
  endfunction

  task automatic compare_byte(input string what, input z80_bus_pkg::byte_t expected,
                              input z80_bus_pkg::byte_t actual);
    test_checks++;
    total_checks++;
    if (actual !== expected) begin
      test_errors++;
      error_count++;
      $display("Error in %s: %s expected %02h, actual %02h", test_name, what, expected, actual);
    end
  endtask

  // swaps one model register with its shadow
  task automatic swap_entry(input int index);
    z80_bus_pkg::byte_t held;
    held                = model_regs[index];
    model_regs[index]   = model_shadow[index];
    model_shadow[index] = held;
  endtask

  // --------------------
  // ALU reference
  // --------------------

  // works on plain integers so carries and borrows come from the arithmetic itself
  task automatic apply_alu(input z80_alu_pkg::alu_op_t op, input z80_bus_pkg::byte_t operand);
    int                 a;
    int                 b;
    int                 c;
    int                 r;
    int                 sr;
    z80_bus_pkg::byte_t f;
    z80_bus_pkg::byte_t res;
    a = int'(model_regs[z80_bus_pkg::REG_A]);
    b = int'(operand);
    f = model_regs[z80_bus_pkg::REG_F];
    c = (op == z80_alu_pkg::ADC) ? int'(f[`Z80_FLAG_C]) : 0;
    r = a;
    case (op)
      z80_alu_pkg::ADD, z80_alu_pkg::ADC: begin
        r  = a + b + c;
        sr = as_signed(a) + as_signed(b) + c;
        f[`Z80_FLAG_H]  = ((a % 16) + (b % 16) + c) > 15;
        f[`Z80_FLAG_PV] = (sr > 127) || (sr < -128);
        f[`Z80_FLAG_N]  = 1'b0;
        f[`Z80_FLAG_C]  = r > 255;
      end
      z80_alu_pkg::SUB: begin
        r  = a - b;
        sr = as_signed(a) - as_signed(b);
        f[`Z80_FLAG_H]  = (a % 16) < (b % 16);
        f[`Z80_FLAG_PV] = (sr > 127) || (sr < -128);
        f[`Z80_FLAG_N]  = 1'b1;
        f[`Z80_FLAG_C]  = a < b;
      end
      z80_alu_pkg::INC: begin
        r = a + 1;
        f[`Z80_FLAG_H]  = (a % 16) == 15;
        f[`Z80_FLAG_PV] = a == 127;
        f[`Z80_FLAG_N]  = 1'b0;
      end
      z80_alu_pkg::DEC: begin
        r = a - 1;
        f[`Z80_FLAG_H]  = (a % 16) == 0;
        f[`Z80_FLAG_PV] = a == 128;
        f[`Z80_FLAG_N]  = 1'b1;
      end
      z80_alu_pkg::CPL: begin
        r = 255 - a;
        f[`Z80_FLAG_H] = 1'b1;
        f[`Z80_FLAG_N] = 1'b1;
      end
      z80_alu_pkg::CCF: begin
        // H takes the carry before it flips
        f[`Z80_FLAG_H] = f[`Z80_FLAG_C];
        f[`Z80_FLAG_N] = 1'b0;
        f[`Z80_FLAG_C] = ~f[`Z80_FLAG_C];
      end
      default: ;
    endcase
    res = 8'(r);
    // sign and zero follow the result for the five arithmetic ops only
    if (op != z80_alu_pkg::CPL && op != z80_alu_pkg::CCF) begin
      f[`Z80_FLAG_S] = res[7];
      f[`Z80_FLAG_Z] = (res == 8'h00);
    end
    model_regs[z80_bus_pkg::REG_A] = res;
    model_regs[z80_bus_pkg::REG_F] = f;
  endtask

  // --------------------
  // command model
  // --------------------

  // the command fields are still held by the driver when ack first shows
  task automatic check_command();
    z80_bus_pkg::byte_t expected;
    expected = last_result;
    case (cmd_kind)
      z80_bus_pkg::LOAD_IMM: begin
        expected            = data_in;
        model_regs[cmd_dst] = data_in;
      end
      z80_bus_pkg::MOVE: begin
        expected            = model_regs[cmd_src];
        model_regs[cmd_dst] = expected;
      end
      z80_bus_pkg::READ: expected = model_regs[cmd_src];
      z80_bus_pkg::ALU: begin
        // the operand is what travelled on the bus
        expected = model_regs[cmd_src];
        apply_alu(cmd_alu_op, expected);
      end
      z80_bus_pkg::EXX: begin
        for (int i = 0; i < 6; i++) begin
          swap_entry(i);
        end
      end
      z80_bus_pkg::EX_AF: begin
        swap_entry(6);
        swap_entry(7);
      end
      default: ;
    endcase
    compare_byte("result_data", expected, result_data);
    compare_byte("flags", model_regs[z80_bus_pkg::REG_F], flags);
    last_result = expected;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        model_regs[i]   = '0;
        model_shadow[i] = '0;
      end
      last_result  = '0;
      ack_q        = 1'b0;
      test_checks  = 0;
      test_errors  = 0;
      total_checks = 0;
      tests_run    = 0;
      error_count  = 0;
    end else begin
      if (ack && !ack_q) begin
        check_command();
      end else if (ack) begin
        // while req is held nothing may move
        compare_byte("held result_data", last_result, result_data);
        compare_byte("held flags", model_regs[z80_bus_pkg::REG_F], flags);
      end
      ack_q = ack;
      if (test_done) begin
        $display("test %s finished: %0d checks, %0d errors", test_name, test_checks,
                 test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
      end
      if (run_done) begin
        $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, error_count);
      end
    end
  end

endmodule

// File: tests/tb_z80_datapath.sv
`timescale 1ns/1ps

module tb_z80_datapath;

  localparam int TIMEOUT_CYCLES = 64;
  localparam int CMDS_PER_TEST  = 60;

  logic                   clk;
  logic                   reset;
  logic                   req;
  logic                   ack;
  z80_bus_pkg::cmd_kind_t cmd_kind;
  z80_bus_pkg::reg_sel_t  cmd_dst;
  z80_bus_pkg::reg_sel_t  cmd_src;
  z80_alu_pkg::alu_op_t   cmd_alu_op;
  z80_bus_pkg::byte_t     data_in;
  z80_bus_pkg::byte_t     result_data;
  z80_bus_pkg::byte_t     flags;

  integer                 seed;
  logic                   timed_out;
  string                  test_name;
  logic                   test_done;
  logic                   run_done;
  int                     error_count;

  z80_datapath z80_datapath_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .cmd_kind    (cmd_kind),
    .cmd_dst     (cmd_dst),
    .cmd_src     (cmd_src),
    .cmd_alu_op  (cmd_alu_op),
    .data_in     (data_in),
    .ack         (ack),
    .result_data (result_data),
    .flags       (flags)
  );

  datapath_checker checker_i (
    .clk         (clk),
    .reset       (reset),
    .ack         (ack),
    .cmd_kind    (cmd_kind),
    .cmd_dst     (cmd_dst),
    .cmd_src     (cmd_src),
    .cmd_alu_op  (cmd_alu_op),
    .data_in     (data_in),
    .result_data (result_data),
    .flags       (flags),
    .test_name   (test_name),
    .test_done   (test_done),
    .run_done    (run_done),
    .error_count (error_count)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // random helpers
  // --------------------
  function automatic int random_below(input int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  function automatic z80_bus_pkg::reg_sel_t random_reg();
    return z80_bus_pkg::reg_sel_t'(3'($random(seed)));
  endfunction

  // loads and reads mixed in among the two exchanges
  function automatic z80_bus_pkg::cmd_kind_t exchange_mix_kind();
    case (random_below(4))
      0: return z80_bus_pkg::LOAD_IMM;
      1: return z80_bus_pkg::READ;
      2: return z80_bus_pkg::EXX;
      default: return z80_bus_pkg::EX_AF;
    endcase
  endfunction

  // --------------------
  // handshake driver
  // --------------------

  // one full four-phase cycle, req stays up hold_cycles edges past the ack
  task automatic send_command(
    input z80_bus_pkg::cmd_kind_t kind,
    input z80_bus_pkg::reg_sel_t  dst,
    input z80_bus_pkg::reg_sel_t  src,
    input int                     hold_cycles
  );
    int waited;
    if (!timed_out) begin
      @(posedge clk);
      cmd_kind   <= kind;
      cmd_dst    <= dst;
      cmd_src    <= src;
      cmd_alu_op <= z80_alu_pkg::alu_op_t'(4'(random_below(7)));
      data_in    <= 8'($random(seed));
      req        <= 1'b1;
      waited = 0;
      while (!ack && waited < TIMEOUT_CYCLES) begin
        @(posedge clk);
        waited++;
      end
      if (!ack) begin
        $display("timeout: no ack within %0d cycles of a %s command", TIMEOUT_CYCLES,
                 kind.name());
        timed_out = 1'b1;
      end else begin
        repeat (hold_cycles) @(posedge clk);
        req <= 1'b0;
        waited = 0;
        while (ack && waited < TIMEOUT_CYCLES) begin
          @(posedge clk);
          waited++;
        end
        if (ack) begin
          $display("timeout: ack still high %0d cycles after req dropped", TIMEOUT_CYCLES);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  // one pulse tells the checker to print its line for the test
  task automatic finish_test();
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  task automatic read_all_regs();
    for (int r = 0; r < 8; r++) begin
      send_command(z80_bus_pkg::READ, z80_bus_pkg::REG_B, z80_bus_pkg::reg_sel_t'(3'(r)), 0);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    seed       = 84306;
    timed_out  = 1'b0;
    reset      = 1'b1;
    req        = 1'b0;
    cmd_kind   = z80_bus_pkg::READ;
    cmd_dst    = z80_bus_pkg::REG_B;
    cmd_src    = z80_bus_pkg::REG_B;
    cmd_alu_op = z80_alu_pkg::ADD;
    data_in    = '0;
    test_name  = "reset_values";
    test_done  = 1'b0;
    run_done   = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // every register and F read back as zero
    read_all_regs();
    finish_test();

    test_name <= "load_move";
    repeat (CMDS_PER_TEST) begin
      send_command(z80_bus_pkg::cmd_kind_t'(3'(random_below(3))), random_reg(), random_reg(), 0);
    end
    finish_test();

    // a fresh load before each ALU op, then A is read back
    test_name <= "alu_ops";
    repeat (CMDS_PER_TEST) begin
      send_command(z80_bus_pkg::LOAD_IMM, random_reg(), random_reg(), 0);
      send_command(z80_bus_pkg::ALU, random_reg(), random_reg(), 0);
      send_command(z80_bus_pkg::READ, random_reg(), z80_bus_pkg::REG_A, 0);
    end
    finish_test();

    test_name <= "exchanges";
    repeat (CMDS_PER_TEST) begin
      send_command(exchange_mix_kind(), random_reg(), random_reg(), 0);
    end
    // the first pass shows the shadow banks, the second brings the values back
    for (int pass = 0; pass < 2; pass++) begin
      send_command(z80_bus_pkg::EXX, random_reg(), random_reg(), 0);
      send_command(z80_bus_pkg::EX_AF, random_reg(), random_reg(), 0);
      read_all_regs();
    end
    finish_test();

    test_name <= "held_request";
    repeat (CMDS_PER_TEST) begin
      send_command(z80_bus_pkg::cmd_kind_t'(3'(random_below(6))), random_reg(), random_reg(),
                   1 + random_below(8));
    end
    finish_test();

    run_done <= 1'b1;
    @(posedge clk);
    run_done <= 1'b0;
    @(posedge clk);
    if (timed_out || error_count != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

// File: tests/z80_datapath_assertions.sv
`timescale 1ns/1ps

module z80_datapath_assertions (
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack
);

  // --------------------
  // handshake rules
  // --------------------

  // ack is a register, so it is low from the edge after reset is seen
  reset_clears_ack: assert property (@(posedge clk) reset |=> !ack)
    else $error("ack is high while reset is asserted");

  // an ack only ever answers a pending req
  ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
    else $error("ack rose without a req");

  // ack holds until an edge has seen req low
  ack_held: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
    else $error("ack dropped while req was still high");

  // a raised req waits for its ack
  req_held: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req)
    else $error("req dropped before ack arrived");

endmodule

bind z80_datapath z80_datapath_assertions z80_datapath_assertions_i (
  .clk   (clk),
  .reset (reset),
  .req   (req),
  .ack   (ack)
);
